//--- verification/mdu_testdata.txt
# group(dec) op(hex, mdu_op_e code) rs1(hex) rs2(hex) expected_rd(hex)
# groups: 1 low product, 2 high product, 3 carry-less product
1 0 00000003 00000007 00000015
1 0 FFFFFFFF FFFFFFFF 00000001
1 0 FFFFFFFE 00000005 FFFFFFF6
1 0 12345678 00000010 23456780
1 0 80000000 80000000 00000000
1 0 0000FFFF 0000FFFF FFFE0001
1 0 7FFFFFFF 00000002 FFFFFFFE
2 1 FFFFFFFF FFFFFFFF 00000000
2 1 80000000 80000000 40000000
2 1 80000000 7FFFFFFF C0000000
2 1 FFFFFFFE 00000003 FFFFFFFF
2 2 FFFFFFFF FFFFFFFF FFFFFFFF
2 2 80000000 FFFFFFFF 80000000
2 2 00000002 80000000 00000001
2 3 FFFFFFFF FFFFFFFF FFFFFFFE
2 3 80000000 80000000 40000000
2 3 12345678 00010000 00001234
3 4 00000003 00000003 00000005
3 4 00000005 00000007 0000001B
3 4 FFFFFFFF FFFFFFFF 55555555
3 5 FFFFFFFF FFFFFFFF 55555555
3 6 FFFFFFFF FFFFFFFF AAAAAAAA
3 4 80000000 00000002 00000000
3 5 80000000 00000002 00000001
3 6 80000000 00000002 00000002
3 5 12345678 00000100 00000012
3 6 12345678 00000100 00000024

//--- tb.f
hdl/mdu_pkg.sv
hdl/mdu_issue_if.sv
hdl/mdu_fifo.sv
hdl/mdu_mul_step.sv
hdl/mdu_clmul_step.sv
hdl/mdu_core.sv
hdl/mdu_top.sv
verification/mdu_clock_gen.sv
verification/mdu_properties.sv
verification/mdu_tb.sv

//--- verification/mdu_tb.sv
/*
 * Testbench for the multiply unit.
 * Replays the vector file through the request port, checks each response
 * in order under random back-pressure, then checks flush and reset.
 */
module mdu_tb import mdu_pkg::*; ();

    localparam int TIMEOUT = 300;  // Cycles allowed per wait
    localparam int QUIET   = 40;   // Watch window after flush

    typedef struct packed {
        logic [3:0]      group;
        mdu_op_e         op;
        logic [XLEN-1:0] rs1;
        logic [XLEN-1:0] rs2;
        logic [XLEN-1:0] rd;
    } vector_t;

    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic [XLEN-1:0]  rd;
        logic [3:0]       group;
        logic [7:0]       index;
    } expect_t;

    logic             g_clk;
    logic             rst;
    logic             flush;
    logic             req_valid;
    logic             req_ready;
    mdu_op_e          req_op;
    logic [XLEN-1:0]  req_rs1;
    logic [XLEN-1:0]  req_rs2;
    logic [TAG_W-1:0] req_tag;
    logic             rsp_valid;
    logic             rsp_ready;
    logic [XLEN-1:0]  rsp_rd;
    logic [TAG_W-1:0] rsp_tag;

    vector_t          vectors[$];
    expect_t          pending[$];    // Tags in request order
    logic [15:0]      lfsr;
    logic [TAG_W-1:0] next_tag;
    int               error_count;
    int               check_count;
    int               tests_run;
    int               tests_failed;
    int               grp_checks[4];
    int               grp_errs[4];
    int               order_checks;
    int               order_errs;

    mdu_clock_gen clock_gen (.g_clk(g_clk), .rst(rst));

    mdu_top #(
        .MUL_UNROLL  (4),
        .CLMUL_UNROLL(8),
        .FIFO_DEPTH  (4)
    ) DUT (
        .g_clk    (g_clk),
        .rst      (rst),
        .flush    (flush),
        .req_valid(req_valid),
        .req_ready(req_ready),
        .req_op   (req_op),
        .req_rs1  (req_rs1),
        .req_rs2  (req_rs2),
        .req_tag  (req_tag),
        .rsp_valid(rsp_valid),
        .rsp_ready(rsp_ready),
        .rsp_rd   (rsp_rd),
        .rsp_tag  (rsp_tag)
    );

    // ------------------------------
    // Helpers
    // ------------------------------
    function automatic logic [15:0] next_lfsr(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);  // Taps 16,14,13,11
    endfunction

    function automatic string group_name(input logic [3:0] g);
        case (g)
            4'd1:    return "mul_low";
            4'd2:    return "mul_high";
            default: return "clmul";
        endcase
    endfunction

    task automatic finish_test(input string name, input int checks, input int errs);
        string verdict;
        tests_run++;
        check_count += checks;
        error_count += errs;
        if (errs == 0) begin
            verdict = "ok";
        end else begin
            verdict = "failed";
            tests_failed++;
        end
        $display("test %s: %s, %0d checks, %0d errors", name, verdict, checks, errs);
    endtask

    task automatic load_vectors();
        int              fd;
        int              fields;
        int              grp;
        int              op;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] r;
        string           line;
        fd = $fopen("verification/mdu_testdata.txt", "r");
        if (fd == 0) begin
            $display("cannot open verification/mdu_testdata.txt");
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            fields = $sscanf(line, "%d %h %h %h %h", grp, op, a, b, r);  // Comments give 0
            if (fields == 5 && grp >= 1 && grp <= 3 && op >= 0 && op <= 6) begin
                vectors.push_back('{group: 4'(grp), op: mdu_op_e'(op[2:0]),
                                    rs1: a, rs2: b, rd: r});
            end
        end
        $fclose(fd);
    endtask

    // Call on a rising edge; returns on the edge of the transfer
    task automatic send_request(input vector_t v, input logic [TAG_W-1:0] tag, output bit ok);
        int waited;
        req_valid <= 1'b1;
        req_op    <= v.op;
        req_rs1   <= v.rs1;
        req_rs2   <= v.rs2;
        req_tag   <= tag;
        waited = 0;
        do begin
            @(posedge g_clk);
            waited++;
        end while (req_ready !== 1'b1 && waited < TIMEOUT);
        ok = (req_ready === 1'b1);
        if (!ok) begin
            $display("timeout: req_ready stayed low for %0d cycles", TIMEOUT);
        end
    endtask

    task automatic await_response(output logic [XLEN-1:0] rd, output logic [TAG_W-1:0] tag,
                                  output bit ok);
        int waited;
        rsp_ready <= 1'b1;
        waited = 0;
        do begin
            @(posedge g_clk);
            waited++;
        end while (rsp_valid !== 1'b1 && waited < TIMEOUT);
        ok  = (rsp_valid === 1'b1);
        rd  = rsp_rd;
        tag = rsp_tag;
        rsp_ready <= 1'b0;
        if (!ok) begin
            $display("timeout: no response within %0d cycles", TIMEOUT);
        end
    endtask

    // ------------------------------
    // Tests
    // ------------------------------
    task automatic check_reset();
        int               waited;
        int               errs;
        int               checks;
        bit               ok;
        logic [XLEN-1:0]  rd;
        logic [TAG_W-1:0] tag;
        errs   = 0;
        checks = 0;
        waited = 0;
        @(posedge g_clk);
        do begin
            @(negedge g_clk);  // Mid-cycle sample
            waited++;
            checks++;
            if (rsp_valid !== 1'b0) begin
                $display("rsp_valid not low during or right after reset");
                errs++;
            end
            if (rst && req_ready !== 1'b0) begin
                $display("req_ready high during reset");
                errs++;
            end
        end while (rst && waited < TIMEOUT);
        if (rst) begin
            $display("timeout: reset was never released");
            errs++;
        end
        @(posedge g_clk);
        send_request(vectors[0], next_tag, ok);
        req_valid <= 1'b0;
        if (ok) begin
            await_response(rd, tag, ok);
        end
        if (!ok) begin
            errs++;
        end else begin
            checks++;
            if (rd !== vectors[0].rd || tag !== next_tag) begin
                $display("mismatch in reset: expected %08h tag %0d, actual %08h tag %0d",
                         vectors[0].rd, next_tag, rd, tag);
                errs++;
            end
        end
        next_tag++;
        finish_test("reset", checks, errs);
    endtask

    task automatic drive_stream();
        bit ok;
        for (int i = 0; i < vectors.size(); i++) begin
            send_request(vectors[i], next_tag, ok);
            if (!ok) begin
                order_errs++;
                break;
            end
            pending.push_back('{tag: next_tag, rd: vectors[i].rd,
                                group: vectors[i].group, index: 8'(i)});
            next_tag++;
        end
        req_valid <= 1'b0;
    endtask

    task automatic collect_stream(input int total);
        int      received;
        int      waited;
        expect_t head;
        received = 0;
        while (received < total) begin
            waited = 0;
            do begin
                lfsr = next_lfsr(lfsr);
                rsp_ready <= lfsr[0];  // One LFSR bit per cycle
                @(posedge g_clk);
                waited++;
            end while (!(rsp_valid === 1'b1 && rsp_ready) && waited < TIMEOUT);
            if (!(rsp_valid === 1'b1 && rsp_ready)) begin
                $display("timeout: response %0d of %0d never arrived", received + 1, total);
                order_errs++;
                break;
            end
            received++;
            order_checks++;
            if (pending.size() == 0) begin
                $display("response with tag %0d arrived with no request outstanding", rsp_tag);
                order_errs++;
                continue;
            end
            head = pending.pop_front();
            if (rsp_tag !== head.tag) begin
                $display("mismatch in ordering (vector %0d): expected tag %0d, actual tag %0d",
                         head.index, head.tag, rsp_tag);
                order_errs++;
            end
            grp_checks[head.group]++;
            if (rsp_rd !== head.rd) begin
                $display("mismatch in %s (vector %0d): expected %08h, actual %08h",
                         group_name(head.group), head.index, head.rd, rsp_rd);
                grp_errs[head.group]++;
            end
        end
        rsp_ready <= 1'b0;
    endtask

    task automatic run_stream();
        @(posedge g_clk);
        fork
            drive_stream();
            collect_stream(vectors.size());
        join
        if (pending.size() != 0) begin
            $display("%0d responses never arrived", pending.size());
            order_errs++;
            pending.delete();
        end
        for (int g = 1; g <= 3; g++) begin
            finish_test(group_name(4'(g)), grp_checks[g], grp_errs[g]);
        end
        finish_test("ordering", order_checks, order_errs);
    endtask

    task automatic run_flush_test();
        int               errs;
        int               checks;
        bit               ok;
        logic [XLEN-1:0]  rd;
        logic [TAG_W-1:0] tag;
        vector_t          fresh;
        errs   = 0;
        checks = 1;
        fresh  = vectors[vectors.size() - 1];
        @(posedge g_clk);
        rsp_ready <= 1'b0;
        for (int i = 0; i < 4; i++) begin
            send_request(vectors[i], next_tag, ok);
            next_tag++;
            if (!ok) begin
                errs++;
            end
        end
        req_valid <= 1'b0;
        flush     <= 1'b1;  // First request still in the core
        @(posedge g_clk);
        flush     <= 1'b0;
        rsp_ready <= 1'b1;
        for (int c = 0; c < QUIET; c++) begin
            @(posedge g_clk);
            if (rsp_valid !== 1'b0) begin
                $display("response with tag %0d came out after flush", rsp_tag);
                errs++;
            end
        end
        send_request(fresh, next_tag, ok);
        req_valid <= 1'b0;
        if (ok) begin
            await_response(rd, tag, ok);
        end
        if (!ok) begin
            errs++;
        end else begin
            checks++;
            if (rd !== fresh.rd || tag !== next_tag) begin
                $display("mismatch in flush: expected %08h tag %0d, actual %08h tag %0d",
                         fresh.rd, next_tag, rd, tag);
                errs++;
            end
        end
        next_tag++;
        finish_test("flush", checks, errs);
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        flush     = 1'b0;
        req_valid = 1'b0;
        req_op    = MUL;
        req_rs1   = '0;
        req_rs2   = '0;
        req_tag   = '0;
        rsp_ready = 1'b0;
        lfsr      = 16'd44651;
        next_tag  = '0;
        load_vectors();
        if (vectors.size() < 4) begin
            $display("too few test vectors read from the data file");
            error_count++;
        end else begin
            check_reset();
            run_stream();
            run_flush_test();
        end
        if (DUT.handshake_props.assert_failures != 0) begin
            $display("%0d handshake assertions failed", DUT.handshake_props.assert_failures);
            error_count += DUT.handshake_props.assert_failures;
        end
        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, check_count, error_count);
        if (error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- verification/mdu_properties.sv
/*
 * Handshake assertions for the multiply unit top level.
 * Bound into every mdu_top instance.
 */
module mdu_properties import mdu_pkg::*; (
    input logic             g_clk,
    input logic             rst,
    input logic             flush,
    input logic             req_valid,
    input logic             req_ready,
    input mdu_op_e          req_op,
    input logic [XLEN-1:0]  req_rs1,
    input logic [XLEN-1:0]  req_rs2,
    input logic [TAG_W-1:0] req_tag,
    input logic             rsp_valid,
    input logic             rsp_ready,
    input logic [XLEN-1:0]  rsp_rd,
    input logic [TAG_W-1:0] rsp_tag
);

    int assert_failures = 0;  // Read by the testbench at the end

    // A stalled request keeps valid and its payload
    req_hold: assert property (@(posedge g_clk) disable iff (rst)
        (req_valid && !req_ready && !flush) |=>
        (req_valid && $stable({req_op, req_rs1, req_rs2, req_tag})))
    else begin
        $error("request changed while stalled");
        assert_failures++;
    end

    // Flush may drop a waiting response, so it is left out
    rsp_hold: assert property (@(posedge g_clk) disable iff (rst)
        (rsp_valid && !rsp_ready && !flush) |=>
        (rsp_valid && $stable({rsp_rd, rsp_tag})))
    else begin
        $error("response changed while stalled");
        assert_failures++;
    end

    rsp_low_in_reset: assert property (@(posedge g_clk) rst |=> !rsp_valid)
    else begin
        $error("rsp_valid high after a reset cycle");
        assert_failures++;
    end

endmodule

bind mdu_top mdu_properties handshake_props (.*);

//--- verification/mdu_clock_gen.sv
/*
 * Clock and reset source for the multiply unit testbench.
 */
module mdu_clock_gen #(
    parameter int PERIOD     = 100,
    parameter int RST_CYCLES = 3
) (
    output logic g_clk,
    output logic rst
);

    initial begin
        g_clk = 1'b0;
        forever begin
            #(PERIOD / 2) g_clk = ~g_clk;
        end
    end

    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge g_clk);
        rst <= 1'b0;  // Released on a rising edge
    end

endmodule

//--- hdl/mdu_top.sv
/*
 * Multiply unit top level.
 * Request queue, iterative core and response queue in a row.
 */
module mdu_top import mdu_pkg::*; #(
    parameter int MUL_UNROLL   = 4,  // Must divide XLEN
    parameter int CLMUL_UNROLL = 8,  // Must divide XLEN
    parameter int FIFO_DEPTH   = 4   // Power of two
) (
    input  logic             g_clk,
    input  logic             rst,
    input  logic             flush,
    input  logic             req_valid,
    output logic             req_ready,
    input  mdu_op_e          req_op,
    input  logic [XLEN-1:0]  req_rs1,
    input  logic [XLEN-1:0]  req_rs2,
    input  logic [TAG_W-1:0] req_tag,
    output logic             rsp_valid,
    input  logic             rsp_ready,
    output logic [XLEN-1:0]  rsp_rd,
    output logic [TAG_W-1:0] rsp_tag
);

    mdu_req_t req_in;
    mdu_req_t req_head;
    mdu_rsp_t core_rsp;
    mdu_rsp_t rsp_head;
    logic     core_rsp_valid;
    logic     core_rsp_ready;

    mdu_issue_if issue_bus ();

    assign req_in        = '{op: req_op, rs1: req_rs1, rs2: req_rs2, tag: req_tag};
    assign issue_bus.op  = req_head.op;
    assign issue_bus.rs1 = req_head.rs1;
    assign issue_bus.rs2 = req_head.rs2;
    assign issue_bus.tag = req_head.tag;
    assign rsp_rd        = rsp_head.rd;
    assign rsp_tag       = rsp_head.tag;

    mdu_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH),
        .T         (mdu_req_t)
    ) req_fifo (
        .g_clk    (g_clk),
        .rst      (rst),
        .flush    (flush),
        .in_valid (req_valid),
        .in_ready (req_ready),
        .in_data  (req_in),
        .out_valid(issue_bus.valid),
        .out_ready(issue_bus.ready),
        .out_data (req_head)
    );

    mdu_core #(
        .MUL_UNROLL  (MUL_UNROLL),
        .CLMUL_UNROLL(CLMUL_UNROLL)
    ) core (
        .g_clk    (g_clk),
        .rst      (rst),
        .flush    (flush),
        .issue    (issue_bus.core),
        .rsp_valid(core_rsp_valid),
        .rsp_ready(core_rsp_ready),
        .rsp      (core_rsp)
    );

    mdu_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH),
        .T         (mdu_rsp_t)
    ) rsp_fifo (
        .g_clk    (g_clk),
        .rst      (rst),
        .flush    (flush),
        .in_valid (core_rsp_valid),
        .in_ready (core_rsp_ready),
        .in_data  (core_rsp),
        .out_valid(rsp_valid),
        .out_ready(rsp_ready),
        .out_data (rsp_head)
    );

endmodule

//--- hdl/mdu_core.sv
/*
 * Multiply sequencer for one operation at a time.
 * Holds operands, accumulator and step counter, then the result
 * until the response queue takes it.
 */
module mdu_core import mdu_pkg::*; #(
    parameter int MUL_UNROLL   = 4,
    parameter int CLMUL_UNROLL = 8
) (
    input  logic      g_clk,
    input  logic      rst,
    input  logic      flush,
    mdu_issue_if.core issue,
    output logic      rsp_valid,
    input  logic      rsp_ready,
    output mdu_rsp_t  rsp
);

    localparam int MUL_STEPS   = XLEN / MUL_UNROLL;
    localparam int CLMUL_STEPS = XLEN / CLMUL_UNROLL;
    localparam int CNT_W       = $clog2(XLEN + 1);

    mdu_op_e          op_q;
    logic [XLEN-1:0]  rs1_q;
    logic [XLEN-1:0]  rs2_q;    // Shifted down as bits retire
    logic [TAG_W-1:0] tag_q;
    logic [MLEN-1:0]  acc;
    logic [CNT_W-1:0] count;    // Steps left
    logic             running;
    logic             done;     // Result waiting for response queue

    logic             accept;
    logic             is_clmul;
    logic             last;
    logic             lhs_signed;
    logic             rhs_signed;
    logic [MLEN-1:0]  mul_next;
    logic [MLEN-1:0]  clmul_next;
    logic [XLEN-1:0]  result;

    assign issue.ready = !running && !done;
    assign accept      = issue.valid && issue.ready;
    assign is_clmul    = op_q inside {CLMUL, CLMULH, CLMULR};
    assign lhs_signed  = op_q inside {MULH, MULHSU};
    assign rhs_signed  = (op_q == MULH);
    assign last        = (count == CNT_W'(1));

    // ------------------------------
    // Step datapaths
    // ------------------------------
    mdu_mul_step #(
        .MUL_UNROLL(MUL_UNROLL)
    ) mul_step (
        .acc            (acc),
        .multiplicand   (rs1_q),
        .multiplier_bits(rs2_q[MUL_UNROLL-1:0]),
        .lhs_signed     (lhs_signed),
        .rhs_signed     (rhs_signed),
        .last           (last),
        .acc_next       (mul_next)
    );

    mdu_clmul_step #(
        .CLMUL_UNROLL(CLMUL_UNROLL)
    ) clmul_step (
        .acc            (acc),
        .multiplicand   (rs1_q),
        .multiplier_bits(rs2_q[CLMUL_UNROLL-1:0]),
        .acc_next       (clmul_next)
    );

    // ------------------------------
    // Control
    // ------------------------------
    always_ff @(posedge g_clk) begin
        if (rst || flush) begin
            running <= 1'b0;
            done    <= 1'b0;
            count   <= '0;
        end else if (accept) begin
            running <= 1'b1;
            count   <= (issue.op inside {CLMUL, CLMULH, CLMULR}) ?
                       CNT_W'(CLMUL_STEPS) : CNT_W'(MUL_STEPS);
        end else if (running) begin
            count <= count - 1'b1;
            if (last) begin
                running <= 1'b0;
                done    <= 1'b1;  // Valid N cycles after accept
            end
        end else if (done && rsp_ready) begin
            done <= 1'b0;
        end
    end

    // Operands and accumulator
    always_ff @(posedge g_clk) begin
        if (accept) begin
            op_q  <= issue.op;
            rs1_q <= issue.rs1;
            rs2_q <= issue.rs2;
            tag_q <= issue.tag;
            acc   <= '0;
        end else if (running) begin
            acc   <= is_clmul ? clmul_next : mul_next;
            rs2_q <= is_clmul ? (rs2_q >> CLMUL_UNROLL) : (rs2_q >> MUL_UNROLL);
        end
    end

    // Result select
    always_comb begin
        result = acc[XLEN-1:0];
        case (op_q)
            MULH, MULHSU, MULHU, CLMULH: result = acc[MLEN-1:XLEN];
            CLMULR:                      result = acc[MLEN-2:XLEN-1];
            default:                     result = acc[XLEN-1:0];  // MUL, CLMUL
        endcase
    end

    assign rsp_valid = done;
    assign rsp       = '{rd: result, tag: tag_q};

endmodule

//--- hdl/mdu_clmul_step.sv
/*
 * Shift-xor step of the carry-less multiplier.
 * Retires CLMUL_UNROLL multiplier bits per call.
 */
module mdu_clmul_step import mdu_pkg::*; #(
    parameter int CLMUL_UNROLL = 8
) (
    input  logic [MLEN-1:0]         acc,
    input  logic [XLEN-1:0]         multiplicand,
    input  logic [CLMUL_UNROLL-1:0] multiplier_bits,
    output logic [MLEN-1:0]         acc_next
);

    always_comb begin
        logic [MLEN-1:0] state;
        logic [XLEN-1:0] addend;

        state = acc;
        for (int i = 0; i < CLMUL_UNROLL; i++) begin
            addend = multiplier_bits[i] ? multiplicand : '0;
            // No carries, zero fill from the top
            state  = {1'b0, state[MLEN-1:XLEN] ^ addend, state[XLEN-1:1]};
        end
        acc_next = state;
    end

endmodule

//--- hdl/mdu_mul_step.sv
/*
 * Shift-add step of the integer multiplier.
 * Retires MUL_UNROLL multiplier bits per call, with signed operands
 * and the negative weight of the top bit on the last step.
 */
module mdu_mul_step import mdu_pkg::*; #(
    parameter int MUL_UNROLL = 4
) (
    input  logic [MLEN-1:0]       acc,
    input  logic [XLEN-1:0]       multiplicand,
    input  logic [MUL_UNROLL-1:0] multiplier_bits,
    input  logic                  lhs_signed,
    input  logic                  rhs_signed,
    input  logic                  last,
    output logic [MLEN-1:0]       acc_next
);

    always_comb begin
        logic [MLEN-1:0] state;
        logic [XLEN-1:0] addend;
        logic [XLEN:0]   sum_l;
        logic [XLEN:0]   sum_r;
        logic [XLEN:0]   sum;
        logic            sub;

        state = acc;
        for (int i = 0; i < MUL_UNROLL; i++) begin
            // Top bit of a signed multiplier weighs -2^(XLEN-1)
            sub    = last && rhs_signed && (i == MUL_UNROLL - 1);
            addend = multiplier_bits[i] ? multiplicand : '0;

            // Upper half plus addend, both sign-extended to XLEN+1
            sum_l  = {lhs_signed && state[MLEN-1], state[MLEN-1:XLEN]};
            sum_r  = {lhs_signed && addend[XLEN-1], addend};
            if (sub) begin
                sum_r = ~sum_r;  // Two's complement with carry-in below
            end
            sum    = sum_l + sum_r + {{XLEN{1'b0}}, sub};

            // Carry bit moves into the top, low half shifts down
            state  = {sum, state[XLEN-1:1]};
        end
        acc_next = state;
    end

endmodule

//--- hdl/mdu_fifo.sv
/*
 * Synchronous FIFO with valid/ready on both sides.
 * Payload type set by T; flush empties it in one cycle.
 */
module mdu_fifo #(
    parameter int  FIFO_DEPTH = 4,
    parameter type T          = logic
) (
    input  logic g_clk,
    input  logic rst,
    input  logic flush,
    input  logic in_valid,
    output logic in_ready,
    input  T     in_data,
    output logic out_valid,
    input  logic out_ready,
    output T     out_data
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    T                 mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] count_next;
    logic             push;
    logic             pop;

    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;
    assign out_valid = (count != '0);  // Not empty
    assign out_data  = mem[rd_ptr];

    always_comb begin
        count_next = count;
        if (push && !pop) begin
            count_next = count + 1'b1;
        end else if (pop && !push) begin
            count_next = count - 1'b1;
        end
    end

    // ------------------------------
    // Pointers, occupancy, ready
    // ------------------------------
    always_ff @(posedge g_clk) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            in_ready <= 1'b0;  // Held low through reset
        end else if (flush) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            in_ready <= 1'b1;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;  // Wraps, depth is a power of two
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count    <= count_next;
            in_ready <= (count_next != CNT_W'(FIFO_DEPTH));  // Not full next cycle
        end
    end

    always_ff @(posedge g_clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

endmodule

//--- hdl/mdu_issue_if.sv
/*
 * Issue path from the request queue into the multiply core.
 * One request per valid/ready transfer.
 */
interface mdu_issue_if import mdu_pkg::*; ();

    logic             valid;  // Head of request queue present
    logic             ready;  // Core idle and free
    mdu_op_e          op;
    logic [XLEN-1:0]  rs1;
    logic [XLEN-1:0]  rs2;
    logic [TAG_W-1:0] tag;

    // Request queue side
    modport src (
        output valid, op, rs1, rs2, tag,
        input  ready
    );

    // Multiply core side
    modport core (
        input  valid, op, rs1, rs2, tag,
        output ready
    );

endinterface

//--- hdl/mdu_pkg.sv
/*
 * Shared definitions for the iterative multiply unit.
 * Widths, operation codes and the queue payload types.
 */
package mdu_pkg;

    // ------------------------------
    // Widths
    // ------------------------------
    localparam int XLEN  = 32;        // Operand width
    localparam int MLEN  = 2 * XLEN;  // Double-width accumulator
    localparam int TAG_W = 4;         // Request tag width

    // ------------------------------
    // Operation encoding
    // ------------------------------
    typedef enum logic [2:0] {
        MUL    = 3'd0,  // Low half, sign does not matter
        MULH   = 3'd1,  // Signed x signed
        MULHSU = 3'd2,  // Signed x unsigned
        MULHU  = 3'd3,  // Unsigned x unsigned
        CLMUL  = 3'd4,  // Carry-less low half
        CLMULH = 3'd5,  // Carry-less high half
        CLMULR = 3'd6   // Carry-less bits 62..31
    } mdu_op_e;

    // Request queue entry, 71 bits
    typedef struct packed {
        mdu_op_e          op;
        logic [XLEN-1:0]  rs1;
        logic [XLEN-1:0]  rs2;
        logic [TAG_W-1:0] tag;
    } mdu_req_t;

    // Response queue entry, 36 bits
    typedef struct packed {
        logic [XLEN-1:0]  rd;
        logic [TAG_W-1:0] tag;
    } mdu_rsp_t;

endpackage
